//--- logic/z3_pkg.sv
// shared widths, bus constants, autoconfig table, register offsets and cycle states
package z3_pkg;

	// bus side vectors
	typedef logic [31:0] z3_addr_t;
	// data word in data-phase order, d31 down to d0
	typedef logic [31:0] z3_word_t;
	// byte strobes, active low, ds3 strobes d31..d24
	typedef logic [3:0] z3_strb_t;
	typedef logic [1:0] z3_fc_t;

	// memory side word address, bus address bits 25..2
	typedef logic [23:0] mem_addr_t;

	// autoconfig register index, bus address bits 8..2
	typedef logic [6:0] cfg_reg_t;
	typedef logic [3:0] cfg_nibble_t;

	// no byte lane strobed
	localparam z3_strb_t STRB_NONE = 4'b1111;

	// upper half of the zorro iii config space
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;

	// base address bits compared for a card hit, 64 MB window
	localparam int unsigned CARD_MATCH_MSB = 31;
	localparam int unsigned CARD_MATCH_LSB = 26;

	localparam int unsigned CFG_TABLE_DEPTH = 16;

	// nibbles as driven on d31..d28
	// only register 0 is true polarity, the rest are inverted
	localparam cfg_nibble_t CFG_TABLE [0:CFG_TABLE_DEPTH-1] = '{
		// type: zorro iii board, link into free memory pool
		4'hA,
		// size code
		4'h0,
		// product number 0x01
		4'hF,
		4'hE,
		// flags, memory space board
		4'h7,
		4'hF,
		// reserved
		4'hF,
		4'hF,
		// manufacturer 0x07DB
		4'hF,
		4'h8,
		4'h2,
		4'h4,
		// serial number, low word 0x0001
		4'hF,
		4'hF,
		4'hF,
		4'hE
	};

	// base address write at byte offset 0x44
	localparam cfg_reg_t CFG_REG_BASE = 7'h11;
	// shut-up write at byte offset 0x4c
	localparam cfg_reg_t CFG_REG_SHUTUP = 7'h13;

	// slave cycle states
	typedef enum logic [2:0] {
		ZS_IDLE,
		ZS_MATCH,
		ZS_DATA,
		ZS_WRITE_DATA,
		ZS_DTACK
	} zs_state_e;

endpackage

//--- logic/z3_cycle_if.sv
// resampled bus cycle interface with source, decode and control modports
interface z3_cycle_if;
	import z3_pkg::*;

	// sampled fcs_n is low
	logic fcs_active;
	// one cycle after the sampled falling edge of fcs_n
	logic cycle_start;
	// latched at cycle start, low two bits zero
	z3_addr_t addr;
	logic read;
	logic doe;
	z3_strb_t ds_n;
	z3_fc_t fc;
	// latched on the first strobe of a write
	z3_word_t wdata;

	modport src (
		output fcs_active, cycle_start, addr, read, doe, ds_n, fc, wdata
	);

	// address match only needs the address phase
	modport decode (
		input fcs_active, cycle_start, addr, fc
	);

	modport ctrl (
		input fcs_active, addr, read, doe, ds_n, wdata
	);

endinterface

//--- logic/z3_bus_sync.sv
// bus strobe resampling, address and write data capture, cycle start detect
module z3_bus_sync (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             fcs_n_i,
	input  logic             read_i,
	input  logic             doe_i,
	input  z3_pkg::z3_strb_t ds_n_i,
	input  z3_pkg::z3_fc_t   fc_i,
	input  z3_pkg::z3_word_t bus_ad_i,
	z3_cycle_if.src          cyc
);
	import z3_pkg::*;

	logic fcs_n_q;
	logic fcs_fall;
	logic ds_first;

	// old sample still high, bus already low
	assign fcs_fall = fcs_n_q & ~fcs_n_i;
	// first edge with any byte lane strobed
	assign ds_first = (cyc.ds_n == STRB_NONE) && (ds_n_i != STRB_NONE);

	assign cyc.fcs_active = ~fcs_n_q;

	// strobes and qualifiers, one clock behind the bus
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fcs_n_q <= 1'b1;
			cyc.cycle_start <= 1'b0;
			cyc.read <= 1'b1;
			cyc.doe <= 1'b0;
			cyc.ds_n <= STRB_NONE;
			cyc.fc <= '0;
		end else begin
			fcs_n_q <= fcs_n_i;
			cyc.cycle_start <= fcs_fall;
			cyc.read <= read_i;
			cyc.doe <= doe_i;
			cyc.ds_n <= ds_n_i;
			cyc.fc <= fc_i;
		end
	end

	// address phase, master holds ad for three clocks after fcs falls
	always_ff @(posedge clk) begin
		if (fcs_fall) begin
			cyc.addr <= {bus_ad_i[31:2], 2'b00};
		end
	end

	// write data valid with the strobes
	always_ff @(posedge clk) begin
		if (ds_first) begin
			cyc.wdata <= bus_ad_i;
		end
	end

endmodule

//--- logic/z3_addr_decode.sv
// registered card and config space hits, function code check, slave select
module z3_addr_decode (
	input  logic             clk,
	input  logic             rst_n_i,
	z3_cycle_if.decode       cyc,
	input  z3_pkg::z3_addr_t base_addr_i,
	input  logic             configured_i,
	input  logic             unconfigured_i,
	input  logic             shutup_i,
	input  logic             cfgin_n_i,
	output logic             card_hit_o,
	output logic             cfg_hit_o,
	output logic             slave_n_o
);
	import z3_pkg::*;

	logic card_match;
	logic cfg_match;
	logic fc_ok;

	// card window, only after a base was assigned
	assign card_match = configured_i &&
		(cyc.addr[CARD_MATCH_MSB:CARD_MATCH_LSB] ==
		 base_addr_i[CARD_MATCH_MSB:CARD_MATCH_LSB]);

	// config space needs the chain input from the previous slot
	assign cfg_match = unconfigured_i && !cfgin_n_i &&
		(cyc.addr[31:16] == CFG_SPACE_HI);

	// user or supervisor data/program, not cpu space
	assign fc_ok = cyc.fc[0] ^ cyc.fc[1];

	// hits taken once per cycle and held to the end
	// so a base write does not drop the select mid cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			card_hit_o <= 1'b0;
			cfg_hit_o <= 1'b0;
		end else if (!cyc.fcs_active) begin
			card_hit_o <= 1'b0;
			cfg_hit_o <= 1'b0;
		end else if (cyc.cycle_start) begin
			card_hit_o <= card_match;
			cfg_hit_o <= cfg_match;
		end
	end

	// release as soon as the sampled strobe goes high
	assign slave_n_o = ~((card_hit_o | cfg_hit_o) & fc_ok & ~shutup_i & cyc.fcs_active);

endmodule

//--- logic/z3_autoconfig.sv
// autoconfig register table, base address, configured and shut-up flags, config chain
module z3_autoconfig (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                cfg_we_i,
	input  z3_pkg::cfg_reg_t    cfg_reg_i,
	input  z3_pkg::z3_word_t    cfg_wdata_i,
	output z3_pkg::cfg_nibble_t cfg_rdata_o,
	output z3_pkg::z3_addr_t    base_addr_o,
	output logic                configured_o,
	output logic                unconfigured_o,
	output logic                shutup_o,
	output logic                cfgout_n_o
);
	import z3_pkg::*;

	logic [15:0] base_hi;
	logic        base_we;
	logic        shutup_we;

	// table read
	// indices past the table float high like an empty register
	always_comb begin
		if (cfg_reg_i < CFG_TABLE_DEPTH) begin
			cfg_rdata_o = CFG_TABLE[cfg_reg_i[3:0]];
		end else begin
			cfg_rdata_o = 4'hF;
		end
	end

	// writes only count while still in config space
	assign base_we = cfg_we_i && unconfigured_o && (cfg_reg_i == CFG_REG_BASE);
	assign shutup_we = cfg_we_i && unconfigured_o && (cfg_reg_i == CFG_REG_SHUTUP);

	// base address high word, a31..a16 on d31..d16
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			base_hi <= '0;
		end else if (base_we) begin
			base_hi <= cfg_wdata_i[31:16];
		end
	end

	assign base_addr_o = {base_hi, 16'h0000};

	// configured on the base write
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			configured_o <= 1'b0;
		end else if (base_we) begin
			configured_o <= 1'b1;
		end
	end

	// host has no room for the card
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shutup_o <= 1'b0;
		end else if (shutup_we) begin
			shutup_o <= 1'b1;
		end
	end

	// still answering at ff00xxxx
	assign unconfigured_o = ~configured_o & ~shutup_o;

	// pass the chain on to the next slot
	// either way the card is out of config space
	assign cfgout_n_o = unconfigured_o;

endmodule

//--- logic/z3_cycle_ctrl.sv
// cycle state machine, memory request, read data latch, acknowledge and output enable
module z3_cycle_ctrl (
	input  logic                clk,
	input  logic                rst_n_i,
	z3_cycle_if.ctrl            cyc,
	input  logic                card_hit_i,
	input  logic                cfg_hit_i,
	input  logic                slave_n_i,
	input  z3_pkg::cfg_nibble_t cfg_rdata_i,
	output logic                cfg_we_o,
	output z3_pkg::cfg_reg_t    cfg_reg_o,
	output logic                mem_stb_o,
	output logic                mem_we_o,
	output z3_pkg::mem_addr_t   mem_addr_o,
	output z3_pkg::z3_word_t    mem_wdata_o,
	output z3_pkg::z3_strb_t    mem_be_n_o,
	input  logic                mem_ack_i,
	input  logic                mem_busy_i,
	input  z3_pkg::z3_word_t    mem_rdata_i,
	output z3_pkg::z3_word_t    data_o,
	output logic                data_oe_o,
	output logic                dtack_n_o
);
	import z3_pkg::*;

	zs_state_e state;
	logic      mem_phase;
	logic      mem_launch;
	logic      dtack_q;

	// phases that talk to the memory controller, card space only
	assign mem_phase = card_hit_i &&
		(((state == ZS_DATA) && cyc.read) || (state == ZS_WRITE_DATA));
	assign mem_launch = mem_phase && !mem_stb_o;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ZS_IDLE;
		end else if (!cyc.fcs_active) begin
			// master ended the cycle
			state <= ZS_IDLE;
		end else begin
			case (state)
				ZS_IDLE: begin
					if (!slave_n_i) begin
						state <= ZS_MATCH;
					end
				end
				// back-pressure before data time
				ZS_MATCH: begin
					if (cyc.doe && !mem_busy_i) begin
						state <= ZS_DATA;
					end
				end
				ZS_DATA: begin
					if (cyc.read) begin
						// config reads come straight from the table
						if (!card_hit_i || mem_ack_i) begin
							state <= ZS_DTACK;
						end
					end else if (cyc.ds_n != STRB_NONE) begin
						state <= ZS_WRITE_DATA;
					end
				end
				ZS_WRITE_DATA: begin
					if (!card_hit_i || mem_ack_i) begin
						state <= ZS_DTACK;
					end
				end
				// hold until fcs goes away
				ZS_DTACK: begin
					state <= ZS_DTACK;
				end
				default: begin
					state <= ZS_IDLE;
				end
			endcase
		end
	end

	// strobe held until the ack pulse
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_stb_o <= 1'b0;
		end else if (mem_ack_i) begin
			mem_stb_o <= 1'b0;
		end else if (mem_launch) begin
			mem_stb_o <= 1'b1;
		end
	end

	// request fields frozen at launch
	always_ff @(posedge clk) begin
		if (mem_launch) begin
			mem_addr_o <= cyc.addr[25:2];
			mem_we_o <= ~cyc.read;
			mem_wdata_o <= cyc.wdata;
			mem_be_n_o <= cyc.ds_n;
		end
	end

	// read data, table nibble on d31..d28 with ones below
	always_ff @(posedge clk) begin
		if (mem_stb_o && mem_ack_i && cyc.read) begin
			data_o <= mem_rdata_i;
		end else if ((state == ZS_DATA) && cyc.read && cfg_hit_i) begin
			data_o <= {cfg_rdata_i, {28{1'b1}}};
		end
	end

	// config register write, one clock in write data phase
	assign cfg_we_o = (state == ZS_WRITE_DATA) && cfg_hit_i;
	assign cfg_reg_o = cyc.addr[8:2];

	// dtack one clock after entering the state, data has settled on the bus
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dtack_q <= 1'b0;
		end else begin
			dtack_q <= (state == ZS_DTACK);
		end
	end

	assign dtack_n_o = ~(dtack_q & cyc.fcs_active);

	// drive the data bus only for our own read in data time
	assign data_oe_o = ~slave_n_i & cyc.doe & cyc.read;

endmodule

//--- logic/z3_card.sv
// card top level, bus sync, decode, autoconfig and cycle control on plain ports
module z3_card (
	input  logic              clk,
	input  logic              rst_n_i,
	// zorro iii bus
	input  logic              fcs_n_i,
	input  logic              read_i,
	input  logic              doe_i,
	input  z3_pkg::z3_strb_t  ds_n_i,
	input  z3_pkg::z3_fc_t    fc_i,
	input  z3_pkg::z3_word_t  bus_ad_i,
	input  logic              cfgin_n_i,
	output logic              slave_n_o,
	output logic              dtack_n_o,
	output logic              cfgout_n_o,
	output z3_pkg::z3_word_t  data_o,
	output logic              data_oe_o,
	// memory controller port
	output logic              mem_stb_o,
	output logic              mem_we_o,
	output z3_pkg::mem_addr_t mem_addr_o,
	output z3_pkg::z3_word_t  mem_wdata_o,
	output z3_pkg::z3_strb_t  mem_be_n_o,
	input  logic              mem_ack_i,
	input  logic              mem_busy_i,
	input  z3_pkg::z3_word_t  mem_rdata_i
);
	import z3_pkg::*;

	// decode to control
	logic card_hit;
	logic cfg_hit;
	logic slave_n;
	// autoconfig side block
	logic        cfg_we;
	cfg_reg_t    cfg_reg;
	cfg_nibble_t cfg_rdata;
	z3_addr_t    base_addr;
	logic        configured;
	logic        unconfigured;
	logic        shutup;

	z3_cycle_if u_cyc ();

	z3_bus_sync u_sync (
		.clk(clk), .rst_n_i(rst_n_i), .fcs_n_i(fcs_n_i), .read_i(read_i), .doe_i(doe_i),
		.ds_n_i(ds_n_i), .fc_i(fc_i), .bus_ad_i(bus_ad_i), .cyc(u_cyc.src)
	);

	z3_addr_decode u_decode (
		.clk(clk), .rst_n_i(rst_n_i), .cyc(u_cyc.decode), .base_addr_i(base_addr),
		.configured_i(configured), .unconfigured_i(unconfigured), .shutup_i(shutup),
		.cfgin_n_i(cfgin_n_i), .card_hit_o(card_hit), .cfg_hit_o(cfg_hit), .slave_n_o(slave_n)
	);

	z3_autoconfig u_autocfg (
		.clk(clk), .rst_n_i(rst_n_i), .cfg_we_i(cfg_we), .cfg_reg_i(cfg_reg),
		.cfg_wdata_i(u_cyc.wdata), .cfg_rdata_o(cfg_rdata), .base_addr_o(base_addr),
		.configured_o(configured), .unconfigured_o(unconfigured), .shutup_o(shutup),
		.cfgout_n_o(cfgout_n_o)
	);

	z3_cycle_ctrl u_ctrl (
		.clk(clk), .rst_n_i(rst_n_i), .cyc(u_cyc.ctrl), .card_hit_i(card_hit),
		.cfg_hit_i(cfg_hit), .slave_n_i(slave_n), .cfg_rdata_i(cfg_rdata), .cfg_we_o(cfg_we),
		.cfg_reg_o(cfg_reg), .mem_stb_o(mem_stb_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_be_n_o(mem_be_n_o),
		.mem_ack_i(mem_ack_i), .mem_busy_i(mem_busy_i), .mem_rdata_i(mem_rdata_i),
		.data_o(data_o), .data_oe_o(data_oe_o), .dtack_n_o(dtack_n_o)
	);

	assign slave_n_o = slave_n;

endmodule

//--- verif/z3_mem_model.sv
// memory controller responder with random acknowledge delay, byte-masked storage and busy periods
module z3_mem_model (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              mem_stb_i,
	input  logic              mem_we_i,
	input  z3_pkg::mem_addr_t mem_addr_i,
	input  z3_pkg::z3_word_t  mem_wdata_i,
	input  z3_pkg::z3_strb_t  mem_be_n_i,
	output logic              mem_ack_o,
	output logic              mem_busy_o,
	output z3_pkg::z3_word_t  mem_rdata_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import z3_pkg::*;

	localparam int unsigned SEED = 32'hb848;

	z3_word_t    store [mem_addr_t];
	// last request kept for the testbench
	mem_addr_t   last_addr;
	logic        last_we;
	z3_strb_t    last_be_n;
	z3_word_t    last_wdata;
	int unsigned delay;
	int unsigned busy_left;
	bit          seeded;
	bit          active;
	bit          done;

	// untouched words read back a pattern of their own address
	function automatic z3_word_t read_word(input mem_addr_t a);
		if (store.exists(a)) begin
			return store[a];
		end
		return {~a[7:0], a};
	endfunction

	// lane i written when its strobe is low
	// ds3 strobes d31..d24
	function automatic z3_word_t merge_word(input z3_word_t old, input z3_word_t wr,
			input z3_strb_t be_n);
		z3_word_t res;
		int       i;
		res = old;
		for (i = 0; i < 4; i++) begin
			if (!be_n[i]) begin
				res[8*i +: 8] = wr[8*i +: 8];
			end
		end
		return res;
	endfunction

	always @(posedge clk or negedge rst_n_i) begin
		// all random draws of the responder come from this process
		if (!seeded) begin
			void'($urandom(SEED));
			seeded = 1'b1;
		end
		if (!rst_n_i) begin
			mem_ack_o <= 1'b0;
			mem_busy_o <= 1'b0;
			mem_rdata_o <= '0;
			active = 1'b0;
			done = 1'b0;
			delay = 0;
			busy_left = 0;
		end else begin
			mem_ack_o <= 1'b0;
			if (active) begin
				if (delay == 0) begin
					if (last_we) begin
						store[last_addr] = merge_word(read_word(last_addr), last_wdata, last_be_n);
					end else begin
						mem_rdata_o <= read_word(last_addr);
					end
					mem_ack_o <= 1'b1;
					active = 1'b0;
					done = 1'b1;
				end else begin
					delay--;
				end
			end else if (mem_stb_i && !done) begin
				// answer 1 to 4 clocks after the strobe is seen
				last_addr = mem_addr_i;
				last_we = mem_we_i;
				last_be_n = mem_be_n_i;
				last_wdata = mem_wdata_i;
				delay = $urandom_range(3, 0);
				active = 1'b1;
			end else if (!mem_stb_i) begin
				done = 1'b0;
			end
			// short busy bursts only between requests
			if (busy_left != 0) begin
				busy_left--;
			end else if (!mem_stb_i && !active && ($urandom_range(3, 0) == 0)) begin
				busy_left = $urandom_range(3, 1);
			end
			mem_busy_o <= (busy_left != 0);
		end
	end

endmodule

//--- verif/z3_card_tb.sv
// testbench top, clock and reset, stimulus file reader, bus master cycles, compare tasks, summary
module z3_card_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import z3_pkg::*;

	// response windows in clocks
	localparam int unsigned WAIT_CYCLES = 32;
	localparam int unsigned QUIET_CYCLES = 12;

	logic      clk;
	logic      rst_n_i;
	logic      fcs_n_i;
	logic      read_i;
	logic      doe_i;
	z3_strb_t  ds_n_i;
	z3_fc_t    fc_i;
	z3_word_t  bus_ad_i;
	logic      cfgin_n_i;
	logic      slave_n_o;
	logic      dtack_n_o;
	logic      cfgout_n_o;
	z3_word_t  data_o;
	logic      data_oe_o;
	logic      mem_stb_o;
	logic      mem_we_o;
	mem_addr_t mem_addr_o;
	z3_word_t  mem_wdata_o;
	z3_strb_t  mem_be_n_o;
	logic      mem_ack_i;
	logic      mem_busy_i;
	z3_word_t  mem_rdata_i;

	int unsigned value_errors;
	int unsigned other_errors;

	z3_card u_dut (.*);

	z3_mem_model u_mem (
		.clk(clk), .rst_n_i(rst_n_i), .mem_stb_i(mem_stb_o), .mem_we_i(mem_we_o),
		.mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .mem_be_n_i(mem_be_n_o),
		.mem_ack_o(mem_ack_i), .mem_busy_o(mem_busy_i), .mem_rdata_o(mem_rdata_i)
	);

	always #2 clk = ~clk;

	task automatic check_word(input string name, input z3_word_t got, input z3_word_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_mem_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_strb(input string name, input z3_strb_t got, input z3_strb_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	// two clocks low, then every output must be idle
	task automatic apply_reset();
		@(posedge clk);
		rst_n_i <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		check_bit("slave_n_o", slave_n_o, 1'b1);
		check_bit("dtack_n_o", dtack_n_o, 1'b1);
		check_bit("cfgout_n_o", cfgout_n_o, 1'b1);
		check_bit("mem_stb_o", mem_stb_o, 1'b0);
		check_bit("data_oe_o", data_oe_o, 1'b0);
	endtask

	// one bus cycle as master, address held three clocks before data time
	task automatic run_cycle(input z3_addr_t addr, input z3_fc_t fc, input logic rd,
			input z3_strb_t strb, input z3_word_t wdata, input int unsigned limit,
			output bit slave_seen, output bit dtack_seen, output logic oe);
		int unsigned n;
		@(posedge clk);
		fcs_n_i <= 1'b0;
		bus_ad_i <= addr;
		fc_i <= fc;
		read_i <= rd;
		repeat (3) @(posedge clk);
		n = 0;
		slave_seen = 1'b0;
		while (!slave_seen && n < limit) begin
			@(posedge clk);
			slave_seen = !slave_n_o;
			n++;
		end
		// data time, write data replaces the address on ad
		doe_i <= 1'b1;
		ds_n_i <= strb;
		if (!rd) begin
			bus_ad_i <= wdata;
		end
		n = 0;
		dtack_seen = 1'b0;
		while (!dtack_seen && n < limit) begin
			@(posedge clk);
			dtack_seen = !dtack_n_o;
			n++;
		end
		oe = data_oe_o;
		fcs_n_i <= 1'b1;
		doe_i <= 1'b0;
		ds_n_i <= STRB_NONE;
		read_i <= 1'b1;
		n = 0;
		while ((!slave_n_o || !dtack_n_o) && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (!slave_n_o || !dtack_n_o) begin
			$display("card kept slave_n_o or dtack_n_o low after fcs_n_i went high at %h", addr);
			other_errors++;
		end
	endtask

	task automatic run_op(input string op, input z3_addr_t addr, input z3_fc_t fc,
			input z3_strb_t strb, input z3_word_t data, input z3_word_t exp_v);
		bit   slave_seen;
		bit   dtack_seen;
		logic oe;
		if (op == "reset") begin
			apply_reset();
		end else if (op == "no_response") begin
			run_cycle(addr, fc, 1'b1, strb, data, QUIET_CYCLES, slave_seen, dtack_seen, oe);
			if (slave_seen || dtack_seen) begin
				$display("card answered a cycle it should ignore at %h with fc %h", addr, fc);
				other_errors++;
			end
		end else if (op == "cfg_read" || op == "mem_read" || op == "cfg_write" ||
				op == "mem_write") begin
			run_cycle(addr, fc, (op == "cfg_read" || op == "mem_read"), strb, data,
				WAIT_CYCLES, slave_seen, dtack_seen, oe);
			if (!slave_seen || !dtack_seen) begin
				$display("no slave_n_o or dtack_n_o within the timeout for %s at %h", op, addr);
				other_errors++;
			end else if (op == "cfg_read" || op == "mem_read") begin
				check_word("data_o", data_o, exp_v);
				check_bit("data_oe_o", oe, 1'b1);
				if (op == "mem_read") begin
					check_mem_addr("mem_addr_o", mem_addr_o, addr[25:2]);
					check_bit("mem_we_o", mem_we_o, 1'b0);
				end
			end else if (op == "cfg_write") begin
				check_bit("cfgout_n_o", cfgout_n_o, exp_v[0]);
			end else begin
				check_mem_addr("mem_addr_o", mem_addr_o, addr[25:2]);
				check_mem_addr("u_mem.last_addr", u_mem.last_addr, addr[25:2]);
				check_strb("mem_be_n_o", mem_be_n_o, strb);
				check_word("mem_wdata_o", mem_wdata_o, data);
				check_bit("mem_we_o", mem_we_o, 1'b1);
			end
		end else begin
			$display("unknown operation %s in the stimulus file", op);
			other_errors++;
		end
	endtask

	// hard stop if the stimulus loop never finishes
	initial begin
		#100000;
		$display("simulation time limit reached before the stimulus ended");
		$display("Verification failed");
		$finish;
	end

	initial begin
		int       fd;
		int       n;
		string    line;
		string    op;
		z3_addr_t addr;
		z3_fc_t   fc;
		z3_strb_t strb;
		z3_word_t data;
		z3_word_t exp_v;
		value_errors = 0;
		other_errors = 0;
		clk = 1'b0;
		rst_n_i = 1'b0;
		fcs_n_i = 1'b1;
		read_i = 1'b1;
		doe_i = 1'b0;
		ds_n_i = STRB_NONE;
		fc_i = '0;
		bus_ad_i = '0;
		// first slot in the chain
		cfgin_n_i = 1'b0;
		apply_reset();
		fd = $fopen("verif/z3_card_stimulus.txt", "r");
		if (fd == 0) begin
			$display("stimulus file verif/z3_card_stimulus.txt could not be opened");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// comment and blank lines fail the scan
				if (n > 0 && $sscanf(line, "%s %h %h %h %h %h", op, addr, fc, strb, data,
						exp_v) == 6) begin
					run_op(op, addr, fc, strb, data, exp_v);
				end
			end
			$fclose(fd);
		end
		$display("errors: %0d value mismatches, %0d missing or unexpected responses",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- z3_card.f
logic/z3_pkg.sv
logic/z3_cycle_if.sv
logic/z3_bus_sync.sv
logic/z3_addr_decode.sv
logic/z3_autoconfig.sv
logic/z3_cycle_ctrl.sv
logic/z3_card.sv
verif/z3_mem_model.sv
verif/z3_card_tb.sv

//--- verif/z3_card_stimulus.txt
# columns: op addr fc strb data expect, all hex
# expect is data_o for reads and cfgout_n_o for config writes, unused otherwise
cfg_read    FF000000 1 0 00000000 AFFFFFFF
cfg_read    FF000004 1 0 00000000 0FFFFFFF
cfg_read    FF000008 2 0 00000000 FFFFFFFF
cfg_read    FF00000C 1 0 00000000 EFFFFFFF
cfg_read    FF000010 1 0 00000000 7FFFFFFF
cfg_read    FF000014 1 0 00000000 FFFFFFFF
cfg_read    FF000018 2 0 00000000 FFFFFFFF
cfg_read    FF00001C 1 0 00000000 FFFFFFFF
cfg_read    FF000020 1 0 00000000 FFFFFFFF
cfg_read    FF000024 1 0 00000000 8FFFFFFF
cfg_read    FF000028 2 0 00000000 2FFFFFFF
cfg_read    FF00002C 1 0 00000000 4FFFFFFF
cfg_read    FF000030 1 0 00000000 FFFFFFFF
cfg_read    FF000034 1 0 00000000 FFFFFFFF
cfg_read    FF000038 1 0 00000000 FFFFFFFF
cfg_read    FF00003C 1 0 00000000 EFFFFFFF
cfg_read    FF000040 1 0 00000000 FFFFFFFF
no_response 40000000 1 0 00000000 00000000
no_response FF000000 0 0 00000000 00000000
no_response FF000000 3 0 00000000 00000000
cfg_write   FF000044 1 0 40000000 00000000
no_response FF000000 1 0 00000000 00000000
mem_write   40000010 1 0 11223344 00000000
mem_write   40000010 1 A CAFEBABE 00000000
mem_read    40000010 1 0 00000000 11FE33BE
mem_write   41234568 1 0 DEADBEEF 00000000
mem_write   41234568 2 C 00005566 00000000
mem_write   41234568 1 3 7788FFFF 00000000
mem_read    41234568 2 0 00000000 77885566
mem_write   43FFFFFC 1 0 01234567 00000000
mem_write   43FFFFFC 1 E 000000AB 00000000
mem_write   43FFFFFC 1 7 99000000 00000000
mem_read    43FFFFFC 1 0 00000000 992345AB
mem_read    40000010 2 0 00000000 11FE33BE
reset       00000000 0 0 00000000 00000000
cfg_write   FF00004C 1 0 00000000 00000000
no_response FF000000 1 0 00000000 00000000
no_response 40000000 1 0 00000000 00000000
no_response FF000044 1 0 00000000 00000000
